//--- rtl/brisc_pkg.sv
`default_nettype none

package brisc_pkg;

  // --------------------------------------------------------------------------
  // Geometry
  // --------------------------------------------------------------------------
  localparam int unsigned WORD_WIDTH    = 32;
  localparam int unsigned WORDS_IN_LINE = 4;
  localparam int unsigned LINE_WIDTH    = WORD_WIDTH * WORDS_IN_LINE;
  localparam int unsigned ADDRESS_WIDTH = 8;
  localparam int unsigned MEM_DEPTH     = 64;  // In words
  localparam int unsigned NUM_SETS      = 4;

  // Address split is tag | index | word offset | byte offset
  localparam int unsigned BYTE_OFF_WIDTH = $clog2(WORD_WIDTH / 8);
  localparam int unsigned WORD_OFF_WIDTH = $clog2(WORDS_IN_LINE);
  localparam int unsigned INDEX_WIDTH    = $clog2(NUM_SETS);
  localparam int unsigned TAG_WIDTH      =
      ADDRESS_WIDTH - INDEX_WIDTH - WORD_OFF_WIDTH - BYTE_OFF_WIDTH;

  typedef logic [ADDRESS_WIDTH-1:0]  addr_t;
  typedef logic [WORD_WIDTH-1:0]     word_t;
  typedef word_t [WORDS_IN_LINE-1:0] line_t;  // Word 0 sits in the low bits
  typedef logic [INDEX_WIDTH-1:0]    index_t;
  typedef logic [TAG_WIDTH-1:0]      tag_t;
  typedef logic [WORD_OFF_WIDTH-1:0] word_off_t;

  // --------------------------------------------------------------------------
  // Bus structs
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t wdata;
  } cpu_req_t;

  typedef struct packed {
    word_t rdata;
  } cpu_rsp_t;

  typedef struct packed {
    logic  valid;
    logic  rw;    // High for a store
    addr_t addr;  // Always line aligned
    line_t data;
  } mem_req_t;

  typedef struct packed {
    logic  ready;
    addr_t addr;
    line_t data;
  } mem_resp_t;

  typedef enum logic [1:0] {
    idle,
    lookup,
    fill_wait,
    write_through
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- rtl/cache_tag_array.sv
`timescale 1ns/100ps
`default_nettype none

module cache_tag_array (
  input  wire logic              clk,
  input  wire logic              arst_n,
  input  wire brisc_pkg::index_t index,
  input  wire brisc_pkg::tag_t   tag,
  input  wire logic              tag_we,
  output logic                   hit
);
  import brisc_pkg::*;

  logic [NUM_SETS-1:0] valid_q;
  tag_t                tags_q [NUM_SETS];

  assign hit = valid_q[index] && (tags_q[index] == tag);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
    end else if (tag_we) begin
      valid_q[index] <= 1'b1;
    end
  end

  // A fill writes the tag of the latched address
  always_ff @(posedge clk) begin
    if (tag_we) tags_q[index] <= tag;
  end

endmodule

`default_nettype wire

//--- rtl/cache_line_store.sv
`timescale 1ns/100ps
`default_nettype none

module cache_line_store (
  input  wire logic                 clk,
  input  wire brisc_pkg::index_t    index,
  input  wire logic                 line_we,
  input  wire brisc_pkg::line_t     line_wdata,
  input  wire logic                 word_we,
  input  wire brisc_pkg::word_off_t word_off,
  input  wire brisc_pkg::word_t     word_wdata,
  output brisc_pkg::word_t          rd_word,
  output brisc_pkg::line_t          merged_line
);
  import brisc_pkg::*;

  line_t lines_q [NUM_SETS];

  // Read side
  assign rd_word = lines_q[index][word_off];

  // Same line with the incoming word dropped in for stores and write-through
  always_comb begin
    merged_line           = lines_q[index];
    merged_line[word_off] = word_wdata;
  end

  always_ff @(posedge clk) begin
    if (line_we) begin
      lines_q[index] <= line_wdata;  // A fill replaces the whole line
    end else if (word_we) begin
      lines_q[index] <= merged_line;
    end
  end

endmodule

`default_nettype wire

//--- rtl/memory.sv
`timescale 1ns/100ps
`default_nettype none

module memory #(
  parameter int unsigned MEM_REQ_DELAY  = 2,
  parameter int unsigned MEM_RESP_DELAY = 2
) (
  input  wire logic                clk,
  input  wire logic                arst_n,
  input  wire brisc_pkg::mem_req_t req,
  output brisc_pkg::mem_resp_t     resp
);
  import brisc_pkg::*;

  localparam int unsigned LINE_OFF = BYTE_OFF_WIDTH + WORD_OFF_WIDTH;

  word_t                            mem_q [MEM_DEPTH];
  logic [MEM_REQ_DELAY-1:0]         req_vld;
  mem_req_t                         req_pipe [MEM_REQ_DELAY];
  logic [MEM_RESP_DELAY-1:0]        rsp_vld;
  mem_resp_t                        rsp_pipe [MEM_RESP_DELAY];
  mem_req_t                         at_array;
  logic                             at_valid;
  logic [ADDRESS_WIDTH-LINE_OFF-1:0] line_sel;
  line_t                            rd_line;

  initial $readmemh("mem.hex", mem_q);

  assign at_array = req_pipe[MEM_REQ_DELAY-1];
  assign at_valid = req_vld[MEM_REQ_DELAY-1];
  assign line_sel = at_array.addr[ADDRESS_WIDTH-1:LINE_OFF];

  always_comb begin
    for (int w = 0; w < WORDS_IN_LINE; w++) begin
      rd_line[w] = mem_q[{line_sel, word_off_t'(w)}];
    end
    resp       = rsp_pipe[MEM_RESP_DELAY-1];
    resp.ready = rsp_vld[MEM_RESP_DELAY-1];
  end

  // Whole line store at the delayed address
  always @(posedge clk) begin
    if (at_valid && at_array.rw) begin
      for (int w = 0; w < WORDS_IN_LINE; w++) begin
        mem_q[{line_sel, word_off_t'(w)}] <= at_array.data[w];
      end
    end
  end

  // --------------------------------------------------------------------------
  // Request and response delay pipelines
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_vld <= '0;
      rsp_vld <= '0;
    end else begin
      for (int i = MEM_REQ_DELAY - 1; i > 0; i--) req_vld[i] <= req_vld[i-1];
      req_vld[0] <= req.valid;
      for (int i = MEM_RESP_DELAY - 1; i > 0; i--) rsp_vld[i] <= rsp_vld[i-1];
      rsp_vld[0] <= at_valid && !at_array.rw;  // Stores return nothing
    end
  end

  always_ff @(posedge clk) begin
    for (int i = MEM_REQ_DELAY - 1; i > 0; i--) req_pipe[i] <= req_pipe[i-1];
    req_pipe[0] <= req;
    for (int i = MEM_RESP_DELAY - 1; i > 0; i--) rsp_pipe[i] <= rsp_pipe[i-1];
    rsp_pipe[0] <= '{ready: 1'b1, addr: at_array.addr, data: rd_line};
  end

endmodule

`default_nettype wire

//--- rtl/cache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module cache_ctrl (
  input  wire logic                 clk,
  input  wire logic                 arst_n,
  input  wire logic                 req_valid,
  input  wire brisc_pkg::cpu_req_t  req,
  output logic                      req_ready,
  output logic                      rsp_valid,
  output brisc_pkg::cpu_rsp_t       rsp,
  output brisc_pkg::index_t         index,
  output brisc_pkg::tag_t           tag,
  input  wire logic                 hit,
  output logic                      tag_we,
  output logic                      line_we,
  output brisc_pkg::line_t          line_wdata,
  output logic                      word_we,
  output brisc_pkg::word_off_t      word_off,
  output brisc_pkg::word_t          word_wdata,
  input  wire brisc_pkg::word_t     rd_word,
  input  wire brisc_pkg::line_t     merged_line,
  output brisc_pkg::mem_req_t       mem_req,
  input  wire brisc_pkg::mem_resp_t mem_resp
);
  import brisc_pkg::*;

  localparam int unsigned LINE_OFF = BYTE_OFF_WIDTH + WORD_OFF_WIDTH;

  ctrl_state_t state_q, state_d;
  cpu_req_t    req_q;
  cpu_rsp_t    rsp_q;
  logic        rsp_valid_q;
  mem_req_t    mem_req_q;
  addr_t       line_addr;
  logic        fill_done;

  // Every lookup works on the latched request
  assign index      = req_q.addr[LINE_OFF +: INDEX_WIDTH];
  assign tag        = req_q.addr[ADDRESS_WIDTH-1 -: TAG_WIDTH];
  assign word_off   = req_q.addr[BYTE_OFF_WIDTH +: WORD_OFF_WIDTH];
  assign word_wdata = req_q.wdata;
  assign line_wdata = mem_resp.data;
  assign line_addr  = {req_q.addr[ADDRESS_WIDTH-1:LINE_OFF], {LINE_OFF{1'b0}}};
  assign fill_done  = mem_resp.ready && (mem_resp.addr == line_addr);

  assign req_ready = (state_q == idle);
  assign rsp_valid = rsp_valid_q;
  assign rsp       = rsp_q;
  assign mem_req   = mem_req_q;

  // --------------------------------------------------------------------------
  // Next state and array strobes
  // --------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    tag_we  = 1'b0;
    line_we = 1'b0;
    word_we = 1'b0;
    case (state_q)
      idle: if (req_valid) state_d = lookup;
      lookup: begin
        if (hit) begin
          word_we = req_q.we;  // Store hit merges into the cached line
          state_d = req_q.we ? write_through : idle;
        end else begin
          state_d = fill_wait;
        end
      end
      fill_wait: begin
        if (fill_done) begin
          line_we = 1'b1;
          tag_we  = 1'b1;
          state_d = lookup;  // The retry now hits
        end
      end
      write_through: state_d = idle;
      default: state_d = idle;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q     <= idle;
      rsp_valid_q <= 1'b0;
      mem_req_q   <= '0;
    end else begin
      state_q         <= state_d;
      rsp_valid_q     <= (state_q == lookup) && hit;
      mem_req_q.valid <= 1'b0;
      if (state_q == lookup) begin
        if (hit && req_q.we) begin
          mem_req_q <= '{valid: 1'b1, rw: 1'b1, addr: line_addr, data: merged_line};
        end else if (!hit) begin
          mem_req_q <= '{valid: 1'b1, rw: 1'b0, addr: line_addr, data: '0};
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) req_q <= req;
    if (state_q == lookup && hit) begin
      rsp_q.rdata <= req_q.we ? req_q.wdata : rd_word;  // A store echoes its word
    end
  end

endmodule

`default_nettype wire

//--- rtl/cache_top.sv
`timescale 1ns/100ps
`default_nettype none

module cache_top #(
  parameter int unsigned MEM_REQ_DELAY  = 2,
  parameter int unsigned MEM_RESP_DELAY = 2
) (
  input  wire logic                clk,
  input  wire logic                arst_n,
  input  wire logic                req_valid,
  input  wire brisc_pkg::cpu_req_t req,
  output logic                     req_ready,
  output logic                     rsp_valid,
  output brisc_pkg::cpu_rsp_t      rsp
);
  import brisc_pkg::*;

  index_t    index;
  tag_t      tag;
  logic      hit;
  logic      tag_we;
  logic      line_we;
  line_t     line_wdata;
  logic      word_we;
  word_off_t word_off;
  word_t     word_wdata;
  word_t     rd_word;
  line_t     merged_line;
  mem_req_t  mem_req;
  mem_resp_t mem_resp;

  cache_ctrl u_ctrl (.*);

  cache_tag_array u_tags (.clk, .arst_n, .index, .tag, .tag_we, .hit);

  cache_line_store u_lines (
    .clk, .index, .line_we, .line_wdata, .word_we, .word_off, .word_wdata,
    .rd_word, .merged_line
  );

  // Main memory sits behind the write-through path
  memory #(
    .MEM_REQ_DELAY (MEM_REQ_DELAY),
    .MEM_RESP_DELAY(MEM_RESP_DELAY)
  ) u_mem (
    .clk,
    .arst_n,
    .req (mem_req),
    .resp(mem_resp)
  );

endmodule

`default_nettype wire

//--- test/tb_cache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cache;
  import brisc_pkg::*;

  localparam int unsigned MEM_REQ_DELAY  = 2;
  localparam int unsigned MEM_RESP_DELAY = 3;
  localparam int unsigned NUM_ENTRIES    = 14;
  localparam int unsigned CYCLE_LIMIT    =
      NUM_ENTRIES * (MEM_REQ_DELAY + MEM_RESP_DELAY + 8) + 20;

  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t wdata;
    logic  exp_hit;  // Expected to hit in the cache
  } entry_t;

  logic     clk;
  logic     arst_n;
  logic     req_valid;
  cpu_req_t req;
  logic     req_ready;
  logic     rsp_valid;
  cpu_rsp_t rsp;

  word_t model [MEM_DEPTH];  // Reference copy of main memory
  int    errors = 0;
  int    checks = 0;
  int    cycles = 0;

  // Index is addr[5:4] and tag is addr[7:6]
  entry_t tests [NUM_ENTRIES] = '{
    '{1'b0, 8'h14, 32'h0000_0000, 1'b0},  // Cold miss fills set 1
    '{1'b0, 8'h18, 32'h0000_0000, 1'b1},
    '{1'b1, 8'h14, 32'hDEAD_BEEF, 1'b1},
    '{1'b0, 8'h14, 32'h0000_0000, 1'b1},
    '{1'b0, 8'h10, 32'h0000_0000, 1'b1},  // Neighbours of the stored word
    '{1'b0, 8'h1C, 32'h0000_0000, 1'b1},
    '{1'b0, 8'h54, 32'h0000_0000, 1'b0},  // Another tag in the same set evicts the line
    '{1'b0, 8'h14, 32'h0000_0000, 1'b0},  // Stored word must come back from memory
    '{1'b1, 8'hA8, 32'h1234_5678, 1'b0},  // Store miss
    '{1'b0, 8'hA8, 32'h0000_0000, 1'b1},
    '{1'b0, 8'hE8, 32'h0000_0000, 1'b0},
    '{1'b0, 8'hA4, 32'h0000_0000, 1'b0},
    '{1'b0, 8'hA8, 32'h0000_0000, 1'b1},
    '{1'b0, 8'hFC, 32'h0000_0000, 1'b0}
  };

  cache_top #(
    .MEM_REQ_DELAY (MEM_REQ_DELAY),
    .MEM_RESP_DELAY(MEM_RESP_DELAY)
  ) u_dut (
    .clk      (clk),
    .arst_n   (arst_n),
    .req_valid(req_valid),
    .req      (req),
    .req_ready(req_ready),
    .rsp_valid(rsp_valid),
    .rsp      (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic check_word(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, a response never arrived", cycles);
      $display("tests failed");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial begin
    entry_t e;
    word_t  expected;
    int     wait_cycles;
    arst_n    = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    $readmemh("mem.hex", model);
    repeat (5) @(posedge clk);
    #1 arst_n = 1'b1;
    check_flag(req_ready, 1'b1, "req_ready after reset");
    check_flag(rsp_valid, 1'b0, "rsp_valid after reset");

    for (int n = 0; n < NUM_ENTRIES; n++) begin
      e = tests[n];
      while (!req_ready) begin
        @(posedge clk);
        #1;
      end
      req_valid = 1'b1;
      req       = '{we: e.we, addr: e.addr, wdata: e.wdata};
      @(posedge clk);  // Accepting edge
      #1;
      req_valid = 1'b0;

      wait_cycles = 0;
      while (!rsp_valid) begin
        check_flag(req_ready, 1'b0, $sformatf("entry %0d req_ready while open", n));
        @(posedge clk);
        #1;
        wait_cycles++;
      end

      if (e.we) begin
        expected = e.wdata;  // A store answers with its own word
        model[e.addr[ADDRESS_WIDTH-1:BYTE_OFF_WIDTH]] = e.wdata;
      end else begin
        expected = model[e.addr[ADDRESS_WIDTH-1:BYTE_OFF_WIDTH]];
      end
      check_word(rsp.rdata, expected, $sformatf("entry %0d rdata", n));
      check_flag(wait_cycles == 1, e.exp_hit, $sformatf("entry %0d hit timing", n));

      // One cycle later the pulse is over and the port is free again
      @(posedge clk);
      #1;
      check_flag(rsp_valid, 1'b0, $sformatf("entry %0d rsp_valid pulse", n));
      check_flag(req_ready, 1'b1, $sformatf("entry %0d req_ready after response", n));
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
rtl/brisc_pkg.sv
rtl/cache_tag_array.sv
rtl/cache_line_store.sv
rtl/memory.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
test/tb_cache.sv

//--- mem.hex
// One 32-bit word per line, word address 0 to 63 in order
// Bytes are A5, word address, twice the address, three times the address
A5000000
A5010203
A5020406
A5030609
A504080C
A5050A0F
A5060C12
A5070E15
A5081018
A509121B
A50A141E
A50B1621
A50C1824
A50D1A27
A50E1C2A
A50F1E2D
A5102030
A5112233
A5122436
A5132639
A514283C
A5152A3F
A5162C42
A5172E45
A5183048
A519324B
A51A344E
A51B3651
A51C3854
A51D3A57
A51E3C5A
A51F3E5D
A5204060
A5214263
A5224466
A5234669
A524486C
A5254A6F
A5264C72
A5274E75
A5285078
A529527B
A52A547E
A52B5681
A52C5884
A52D5A87
A52E5C8A
A52F5E8D
A5306090
A5316293
A5326496
A5336699
A534689C
A5356A9F
A5366CA2
A5376EA5
A53870A8
A53972AB
A53A74AE
A53B76B1
A53C78B4
A53D7AB7
A53E7CBA
A53F7EBD
